// ==== rtl/nabp_config_pkg.sv ====
`default_nettype none

package nabp_config_pkg;

    // angle sequencing
    localparam int ANGLE_LENGTH = 8;
    localparam int NUM_ANGLES = 180;
    localparam int LAST_ANGLE = NUM_ANGLES - 1;

    // one projection line, one PE per detector position
    localparam int PROJ_LENGTH = 16;
    localparam int INDEX_WIDTH = 4;

    // sample and accumulator widths
    localparam int DATA_WIDTH = 12;
    // 180 full-scale samples fit in 20 bits
    localparam int ACC_WIDTH = 20;

endpackage

`default_nettype wire

// ==== rtl/nabp_types_pkg.sv ====
`default_nettype none

package nabp_types_pkg;

    import nabp_config_pkg::*;

    // controller sequence
    typedef enum logic [2:0] {
        INIT       = 3'd0,
        FILL       = 3'd1,
        FILL_SHIFT = 3'd2,
        DRAIN      = 3'd3,
        STOP       = 3'd4
    } state_t;

    typedef logic [DATA_WIDTH-1:0] sample_t;
    typedef logic [ACC_WIDTH-1:0] acc_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

endpackage

`default_nettype wire

// ==== rtl/nabp_kick_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface nabp_kick_if
    import nabp_config_pkg::*;
();

    // fill target, valid together with the kicks
    logic [ANGLE_LENGTH-1:0] buff_angle;
    logic buff_sel;

    // one-cycle pulses from the controller
    logic fill_kick;
    logic shift_kick;

    // levels, high while idle
    logic buff_ready;
    logic pe_ready;

    modport control (
        output buff_angle, buff_sel, fill_kick, shift_kick,
        input  buff_ready, pe_ready
    );

    modport buffer (
        input  buff_angle, buff_sel, fill_kick, shift_kick,
        output buff_ready
    );

    modport pe (
        input  shift_kick,
        output pe_ready
    );

endinterface

`default_nettype wire

// ==== rtl/nabp_state_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_state_control
    import nabp_config_pkg::*;
    import nabp_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    nabp_kick_if.control kick,
    output logic         done
);

    state_t state;
    state_t next_state;
    logic [ANGLE_LENGTH-1:0] angle;
    logic buff_sel;
    logic fill_kick;
    logic shift_kick;
    logic next_iteration;

    // both blocks idle in the same cycle
    assign next_iteration = kick.buff_ready && kick.pe_ready;

    assign kick.buff_angle = angle;
    assign kick.buff_sel = buff_sel;
    assign kick.fill_kick = fill_kick;
    assign kick.shift_kick = shift_kick;
    assign done = (state == STOP);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= INIT;
            angle <= '0;
            buff_sel <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // angle and bank already point at the next fill once a kick leaves
            if (fill_kick || shift_kick)
                buff_sel <= ~buff_sel;
            if (fill_kick)
                angle <= angle + 1'b1;
        end
    end

    always_comb
    begin
        next_state = state;
        fill_kick = 1'b0;
        shift_kick = 1'b0;
        case (state)
            INIT:
            begin
                fill_kick = 1'b1;
                next_state = FILL;
            end
            FILL:
            begin
                if (next_iteration)
                begin
                    fill_kick = 1'b1;
                    shift_kick = 1'b1;
                    next_state = FILL_SHIFT;
                end
            end
            FILL_SHIFT:
            begin
                if (next_iteration)
                begin
                    shift_kick = 1'b1;
                    // last line is filled, only its shift remains
                    if (angle <= LAST_ANGLE)
                        fill_kick = 1'b1;
                    else
                        next_state = DRAIN;
                end
            end
            DRAIN:
            begin
                if (kick.pe_ready)
                    next_state = STOP;
            end
            default:
            begin
                next_state = STOP;
            end
        endcase
    end

    // no kicks once the sequence has stopped
    stop_is_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        state == STOP |-> !kick.fill_kick && !kick.shift_kick);

    fill_only_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
        kick.fill_kick |-> kick.buff_ready);

endmodule

`default_nettype wire

// ==== rtl/nabp_projection_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_projection_buffer
    import nabp_config_pkg::*;
    import nabp_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    nabp_kick_if.buffer             kick,
    output logic                    sample_rd,
    output logic [ANGLE_LENGTH-1:0] sample_angle,
    output index_t                  sample_index,
    input  logic                    sample_valid,
    input  sample_t                 sample_data,
    input  index_t                  rd_index,
    output sample_t                 rd_data
);

    sample_t mem [2][PROJ_LENGTH];
    logic [ANGLE_LENGTH-1:0] fill_angle;
    logic fill_sel;
    index_t fill_index;
    logic req;
    logic pending;
    logic ready;

    assign sample_rd = req;
    assign sample_angle = fill_angle;
    assign sample_index = fill_index;
    assign kick.buff_ready = ready;

    // PE row always sees the bank not being filled
    assign rd_data = mem[!fill_sel][rd_index];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_angle <= '0;
            fill_sel <= 1'b0;
            fill_index <= '0;
            req <= 1'b0;
            pending <= 1'b0;
            ready <= 1'b1;
        end
        else
        begin
            req <= 1'b0;
            // a shift-only kick still swaps banks so the last line gets read
            if (kick.fill_kick || kick.shift_kick)
                fill_sel <= kick.buff_sel;
            if (kick.fill_kick)
            begin
                fill_angle <= kick.buff_angle;
                fill_index <= '0;
                ready <= 1'b0;
                req <= 1'b1;
            end
            else if (req)
            begin
                pending <= 1'b1;
            end
            else if (pending && sample_valid)
            begin
                pending <= 1'b0;
                if (fill_index == index_t'(PROJ_LENGTH - 1))
                begin
                    ready <= 1'b1;
                end
                else
                begin
                    fill_index <= fill_index + 1'b1;
                    req <= 1'b1;
                end
            end
        end
    end

    // sample store
    always_ff @(posedge clk)
    begin
        if (pending && sample_valid)
            mem[fill_sel][fill_index] <= sample_data;
    end

    valid_needs_request: assert property (@(posedge clk) disable iff (!reset_n)
        sample_valid |-> pending);

    // a new request never overlaps an outstanding one
    one_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
        sample_rd |-> !pending);

endmodule

`default_nettype wire

// ==== rtl/nabp_pe_row.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_pe_row
    import nabp_config_pkg::*;
    import nabp_types_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    nabp_kick_if.pe kick,
    output index_t  rd_index,
    input  sample_t rd_data,
    input  logic    clear,
    input  index_t  result_index,
    output acc_t    result_data
);

    acc_t acc [PROJ_LENGTH];
    index_t index;
    logic ready;

    assign rd_index = index;
    assign kick.pe_ready = ready;
    assign result_data = acc[result_index];

    // shift sequencer, one detector position per cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            index <= '0;
            ready <= 1'b1;
        end
        else if (kick.shift_kick)
        begin
            index <= '0;
            ready <= 1'b0;
        end
        else if (!ready)
        begin
            index <= index + 1'b1;
            if (index == index_t'(PROJ_LENGTH - 1))
                ready <= 1'b1;
        end
    end

    // accumulators
    always_ff @(posedge clk)
    begin
        if (!reset_n || clear)
        begin
            for (int i = 0; i < PROJ_LENGTH; i++)
                acc[i] <= '0;
        end
        else if (!ready)
        begin
            acc[index] <= acc[index] + acc_t'(rd_data);
        end
    end

    shift_only_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
        kick.shift_kick |-> kick.pe_ready);

    // a shift lasts exactly one line
    shift_length: assert property (@(posedge clk) disable iff (!reset_n)
        kick.shift_kick |=> !ready [*PROJ_LENGTH] ##1 ready);

endmodule

`default_nettype wire

// ==== rtl/nabp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_top
    import nabp_config_pkg::*;
    import nabp_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    clear,
    output logic                    sample_rd,
    output logic [ANGLE_LENGTH-1:0] sample_angle,
    output index_t                  sample_index,
    input  logic                    sample_valid,
    input  sample_t                 sample_data,
    input  index_t                  result_index,
    output acc_t                    result_data,
    output logic                    done
);

    nabp_kick_if kick ();

    // bank read path from PE row to buffer
    index_t rd_index;
    sample_t rd_data;

    nabp_state_control u_state_control (
        .clk     (clk),
        .reset_n (reset_n),
        .kick    (kick.control),
        .done    (done)
    );

    nabp_projection_buffer u_projection_buffer (
        .clk          (clk),
        .reset_n      (reset_n),
        .kick         (kick.buffer),
        .sample_rd    (sample_rd),
        .sample_angle (sample_angle),
        .sample_index (sample_index),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .rd_index     (rd_index),
        .rd_data      (rd_data)
    );

    nabp_pe_row u_pe_row (
        .clk          (clk),
        .reset_n      (reset_n),
        .kick         (kick.pe),
        .rd_index     (rd_index),
        .rd_data      (rd_data),
        .clear        (clear),
        .result_index (result_index),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

// ==== testbench/nabp_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_clock_gen #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 16
)
(
    input  logic restart,
    output logic clk,
    output logic reset_n
);

    logic reset_q = 1'b0;
    int count = 0;

    assign reset_n = reset_q;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset changes on the falling edge, restart begins a new reset
    always @(negedge clk)
    begin
        if (restart)
        begin
            reset_q <= 1'b0;
            count <= 0;
        end
        else if (!reset_q)
        begin
            if (count == RESET_CYCLES - 1)
                reset_q <= 1'b1;
            count <= count + 1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/nabp_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_top_tb
    import nabp_config_pkg::*;
    import nabp_types_pkg::*;
();

    localparam int NUM_ROWS = 5;
    localparam int DONE_TIMEOUT = 60000;
    localparam int RESET_TIMEOUT = 40;

    typedef struct packed {
        sample_t base;
        sample_t angle_step;
        sample_t index_step;
        logic    use_lfsr;
        logic    zero_gap;
    } row_t;

    logic clk;
    logic reset_n;
    logic restart = 1'b0;
    logic clear = 1'b0;
    logic sample_valid = 1'b0;
    sample_t sample_data = '0;
    index_t result_index = '0;
    logic sample_rd;
    logic [ANGLE_LENGTH-1:0] sample_angle;
    index_t sample_index;
    acc_t result_data;
    logic done;

    row_t rows [NUM_ROWS];
    row_t cur_row;
    logic [31:0] lfsr_state = 32'h0861f975;
    int errors = 0;
    int checks = 0;
    int req_count [NUM_ANGLES][PROJ_LENGTH];
    int ref_acc [PROJ_LENGTH];
    int last_angle;
    logic busy = 1'b0;
    int gap_left = 0;
    sample_t pending_sample = '0;

    nabp_clock_gen clock_gen (
        .restart (restart),
        .clk     (clk),
        .reset_n (reset_n)
    );

    nabp_top DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .clear        (clear),
        .sample_rd    (sample_rd),
        .sample_angle (sample_angle),
        .sample_index (sample_index),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .result_index (result_index),
        .result_data  (result_data),
        .done         (done)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int draw_bits(input int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic sample_t linear_sample(input row_t row, input int angle, input int index);
        int v;
        v = int'(row.base) + angle * int'(row.angle_step) + index * int'(row.index_step);
        return sample_t'(v);
    endfunction

    function automatic int expected_sum(input row_t row, input int index);
        int sum;
        sum = 0;
        for (int a = 0; a < NUM_ANGLES; a++)
            sum += int'(linear_sample(row, a, index));
        return sum;
    endfunction

    task automatic check_equal(input string name, input int got, input int expected);
        checks++;
        assert (got == expected)
        else
        begin
            errors++;
            $display("Error: time %0t %s expected %0d got %0d", $time, name, expected, got);
        end
    endtask

    task automatic record_request();
        int a;
        int i;
        sample_t s;
        a = int'(sample_angle);
        i = int'(sample_index);
        checks++;
        assert (a >= last_angle && a <= LAST_ANGLE)
        else
        begin
            errors++;
            $display("Error: time %0t sample_angle expected %0d..%0d got %0d",
                     $time, last_angle, LAST_ANGLE, a);
        end
        if (a < NUM_ANGLES)
        begin
            req_count[a][i]++;
            last_angle = a;
        end
        s = cur_row.use_lfsr ? sample_t'(draw_bits(DATA_WIDTH)) : linear_sample(cur_row, a, i);
        ref_acc[i] += int'(s);
        pending_sample = s;
        gap_left = cur_row.zero_gap ? 0 : draw_bits(2) + 1;
        busy = 1'b1;
    endtask

    // sample source, one request outstanding at a time
    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            sample_valid = 1'b0;
            busy = 1'b0;
        end
        else
        begin
            sample_valid = 1'b0;
            if (busy)
            begin
                if (gap_left == 0)
                begin
                    sample_data = pending_sample;
                    sample_valid = 1'b1;
                    busy = 1'b0;
                end
                else
                    gap_left--;
            end
            if (sample_rd)
                record_request();
        end
    end

    task automatic clear_tracking();
        for (int a = 0; a < NUM_ANGLES; a++)
            for (int i = 0; i < PROJ_LENGTH; i++)
                req_count[a][i] = 0;
        for (int i = 0; i < PROJ_LENGTH; i++)
            ref_acc[i] = 0;
        last_angle = 0;
    endtask

    task automatic apply_reset(output logic ok);
        int cycles;
        restart <= 1'b1;
        @(negedge clk);
        restart <= 1'b0;
        @(negedge clk);
        check_equal("done", int'(done), 0);
        check_equal("sample_rd", int'(sample_rd), 0);
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < RESET_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        ok = (reset_n === 1'b1);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task automatic wait_for_done(output logic ok);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        ok = (done === 1'b1);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("Timeout: done did not rise within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    task automatic check_requests();
        for (int a = 0; a < NUM_ANGLES; a++)
            for (int i = 0; i < PROJ_LENGTH; i++)
                check_equal($sformatf("request count angle %0d index %0d", a, i),
                            req_count[a][i], 1);
    endtask

    task automatic check_results(input logic after_clear);
        int expected;
        for (int i = 0; i < PROJ_LENGTH; i++)
        begin
            @(negedge clk);
            result_index = index_t'(i);
            @(negedge clk);
            if (after_clear)
                expected = 0;
            else if (cur_row.use_lfsr)
                expected = ref_acc[i];
            else
                expected = expected_sum(cur_row, i);
            check_equal($sformatf("result_data[%0d]", i), int'(result_data), expected);
        end
    endtask

    initial
    begin
        int r;
        logic ok;
        logic timed_out;
        // base, angle_step, index_step, use_lfsr, zero_gap
        rows[0] = '{12'd1, 12'd1, 12'd1, 1'b0, 1'b1};
        rows[1] = '{12'd1, 12'd1, 12'd1, 1'b0, 1'b0};
        rows[2] = '{12'd4095, 12'd0, 12'd0, 1'b0, 1'b0};
        rows[3] = '{12'd100, 12'd37, 12'd255, 1'b0, 1'b0};
        rows[4] = '{12'd0, 12'd0, 12'd0, 1'b1, 1'b0};
        timed_out = 1'b0;
        for (r = 0; r < NUM_ROWS && !timed_out; r++)
        begin
            cur_row = rows[r];
            clear_tracking();
            apply_reset(ok);
            if (ok)
                wait_for_done(ok);
            if (ok)
            begin
                check_requests();
                check_results(1'b0);
                @(negedge clk);
                clear = 1'b1;
                @(negedge clk);
                clear = 1'b0;
                check_results(1'b1);
                check_equal("done", int'(done), 1);
            end
            else
                timed_out = 1'b1;
        end
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/nabp_config_pkg.sv
rtl/nabp_types_pkg.sv
rtl/nabp_kick_if.sv
rtl/nabp_state_control.sv
rtl/nabp_projection_buffer.sv
rtl/nabp_pe_row.sv
rtl/nabp_top.sv
testbench/nabp_clock_gen.sv
testbench/nabp_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass message in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module nabp_top_tb -f sim.f -o nabp_sim \
    && ./obj_dir/nabp_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
